// File: soc_mem_defines.svh
`ifndef SOC_MEM_DEFINES_SVH
`define SOC_MEM_DEFINES_SVH

// byte address of memory word 0
`define SOC_MEM_BASE 32'h8000_0000

// memory depth in 64-bit words
`define SOC_MEM_WORDS 256

// serial-port transmit register
`define SOC_SERIAL_ADDR 32'hA000_03F8

// 1 lets the LFSR throttle request acceptance, 0 accepts whenever possible
`define SOC_STALL_ENABLE 1

`endif

// File: soc_mem_pkg.sv
`default_nettype none
`include "soc_mem_defines.svh"

package soc_mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [7:0]  byte_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;

  localparam int MEM_IDX_W = $clog2(`SOC_MEM_WORDS);
  typedef logic [MEM_IDX_W-1:0] word_idx_t;

  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_SERIAL,
    TGT_NONE
  } target_e;

  typedef enum logic [1:0] {
    RES_IDLE,
    RES_READ,
    RES_WRITE
  } result_state_e;

  // decoded request, word_idx only meaningful for TGT_MEM
  typedef struct packed {
    logic      is_write;
    axi_id_t   id;
    word_idx_t word_idx;
    data_t     data;
    strb_t     strb;
    target_e   target;
  } bus_req_t;

  typedef struct packed {
    logic    is_write;
    axi_id_t id;
    data_t   rdata;
    resp_t   resp;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: bus_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_defines.svh"

module bus_decode (
  input  wire                   clk,
  input  wire                   rst_n_i,
  input  wire                   ar_valid_i,
  output logic                  ar_ready_o,
  input  wire soc_mem_pkg::axi_id_t ar_id_i,
  input  wire soc_mem_pkg::addr_t   ar_addr_i,
  input  wire                   aw_valid_i,
  output logic                  aw_ready_o,
  input  wire soc_mem_pkg::axi_id_t aw_id_i,
  input  wire soc_mem_pkg::addr_t   aw_addr_i,
  input  wire                   w_valid_i,
  output logic                  w_ready_o,
  input  wire soc_mem_pkg::data_t   w_data_i,
  input  wire soc_mem_pkg::strb_t   w_strb_i,
  output logic                  req_valid_o,
  input  wire                   req_ready_i,
  output soc_mem_pkg::bus_req_t req_o
);
  import soc_mem_pkg::*;

  localparam bit          STALL_EN    = (`SOC_STALL_ENABLE != 0);
  localparam addr_t       MEM_BASE    = `SOC_MEM_BASE;
  localparam addr_t       MEM_BYTES   = addr_t'(`SOC_MEM_WORDS * 8);
  localparam addr_t       SERIAL_ADDR = `SOC_SERIAL_ADDR;
  localparam logic [19:0] LFSR_SEED   = 20'h00065;

  logic [19:0] lfsr_q;
  logic        go_q;
  logic        req_valid_q;
  bus_req_t    req_q;
  bus_req_t    req_d;
  logic        can_load;
  logic        ar_fire;
  logic        wr_fire;
  addr_t       sel_addr;
  addr_t       offset;

  // x^20 + x^17 + 1, bit 19 is the go/stall decision
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q <= LFSR_SEED;
      go_q   <= 1'b0;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
      go_q   <= STALL_EN ? lfsr_q[19] : 1'b1;
    end
  end

  assign can_load   = go_q && (!req_valid_q || req_ready_i);
  assign ar_ready_o = can_load;
  // reads win, AW and W only enter as a pair
  assign aw_ready_o = can_load && !ar_valid_i && w_valid_i;
  assign w_ready_o  = can_load && !ar_valid_i && aw_valid_i;
  assign ar_fire    = ar_valid_i && ar_ready_o;
  assign wr_fire    = aw_valid_i && aw_ready_o;

  assign sel_addr = ar_valid_i ? ar_addr_i : aw_addr_i;
  // below base wraps high and falls outside memory too
  assign offset   = sel_addr - MEM_BASE;

  always_comb begin
    req_d.is_write = !ar_valid_i;
    req_d.id       = ar_valid_i ? ar_id_i : aw_id_i;
    req_d.word_idx = offset[MEM_IDX_W+2:3];
    req_d.data     = ar_valid_i ? '0 : w_data_i;
    req_d.strb     = ar_valid_i ? '0 : w_strb_i;
    if (sel_addr == SERIAL_ADDR) begin
      req_d.target = TGT_SERIAL;
    end else if (offset < MEM_BYTES) begin
      req_d.target = TGT_MEM;
    end else begin
      req_d.target = TGT_NONE;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
    end else if (ar_fire || wr_fire) begin
      req_valid_q <= 1'b1;
    end else if (req_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire || wr_fire) begin
      req_q <= req_d;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o));

endmodule

`default_nettype wire

// File: mem_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_defines.svh"

module mem_execute (
  input  wire                       clk,
  input  wire                       rst_n_i,
  input  wire                       req_valid_i,
  output logic                      req_ready_o,
  input  wire soc_mem_pkg::bus_req_t req_i,
  output logic                      rsp_valid_o,
  input  wire                       rsp_ready_i,
  output soc_mem_pkg::bus_rsp_t     rsp_o,
  output logic                      serial_valid_o,
  output soc_mem_pkg::byte_t        serial_data_o
);
  import soc_mem_pkg::*;

  localparam int WORDS = `SOC_MEM_WORDS;

  data_t    mem_q [WORDS];
  data_t    word_rd;
  data_t    merged;
  bus_rsp_t rsp_q;
  bus_rsp_t rsp_d;
  logic     rsp_valid_q;
  logic     serial_valid_q;
  byte_t    serial_data_q;
  logic     is_serial_wr;
  logic     take;

  assign is_serial_wr = req_i.is_write && (req_i.target == TGT_SERIAL);
  // at most one byte every other cycle on the serial line
  assign req_ready_o  = (!rsp_valid_q || rsp_ready_i) && !(serial_valid_q && is_serial_wr);
  assign take         = req_valid_i && req_ready_o;

  assign word_rd = mem_q[req_i.word_idx];

  always_comb begin
    merged = word_rd;
    for (int b = 0; b < 8; b++) begin
      if (req_i.strb[b]) begin
        merged[8*b +: 8] = req_i.data[8*b +: 8];
      end
    end
  end

  always_comb begin
    rsp_d.is_write = req_i.is_write;
    rsp_d.id       = req_i.id;
    rsp_d.rdata    = '0;
    rsp_d.resp     = RESP_OKAY;
    if (req_i.target == TGT_MEM && !req_i.is_write) begin
      rsp_d.rdata = word_rd;
    end else if (req_i.target == TGT_NONE) begin
      rsp_d.resp = RESP_DECERR;
    end
  end

  always_ff @(posedge clk) begin
    if (take && req_i.is_write && req_i.target == TGT_MEM) begin
      mem_q[req_i.word_idx] <= merged;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q    <= 1'b0;
      serial_valid_q <= 1'b0;
    end else begin
      if (take) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      serial_valid_q <= take && is_serial_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rsp_q <= rsp_d;
    end
    // low byte only
    if (take && is_serial_wr) begin
      serial_data_q <= req_i.data[7:0];
    end
  end

  assign rsp_valid_o    = rsp_valid_q;
  assign rsp_o          = rsp_q;
  assign serial_valid_o = serial_valid_q;
  assign serial_data_o  = serial_data_q;

  a_serial_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    serial_valid_o |=> !serial_valid_o);

endmodule

`default_nettype wire

// File: resp_result.sv
`timescale 1ns/1ps
`default_nettype none

module resp_result (
  input  wire                       clk,
  input  wire                       rst_n_i,
  input  wire                       rsp_valid_i,
  output logic                      rsp_ready_o,
  input  wire soc_mem_pkg::bus_rsp_t rsp_i,
  output logic                      r_valid_o,
  input  wire                       r_ready_i,
  output soc_mem_pkg::axi_id_t      r_id_o,
  output soc_mem_pkg::data_t        r_data_o,
  output soc_mem_pkg::resp_t        r_resp_o,
  output logic                      b_valid_o,
  input  wire                       b_ready_i,
  output soc_mem_pkg::axi_id_t      b_id_o,
  output soc_mem_pkg::resp_t        b_resp_o
);
  import soc_mem_pkg::*;

  result_state_e state_q;
  result_state_e state_d;
  bus_rsp_t      rsp_q;

  // one slot, free only while idle
  assign rsp_ready_o = (state_q == RES_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      RES_IDLE: begin
        if (rsp_valid_i) begin
          state_d = rsp_i.is_write ? RES_WRITE : RES_READ;
        end
      end
      RES_READ: begin
        if (r_ready_i) begin
          state_d = RES_IDLE;
        end
      end
      RES_WRITE: begin
        if (b_ready_i) begin
          state_d = RES_IDLE;
        end
      end
      default: state_d = RES_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RES_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid_i && rsp_ready_o) begin
      rsp_q <= rsp_i;
    end
  end

  assign r_valid_o = (state_q == RES_READ);
  assign r_id_o    = rsp_q.id;
  assign r_data_o  = rsp_q.rdata;
  assign r_resp_o  = rsp_q.resp;
  assign b_valid_o = (state_q == RES_WRITE);
  assign b_id_o    = rsp_q.id;
  assign b_resp_o  = rsp_q.resp;

  // upstream holds a response until the slot takes it
  a_rsp_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_o |=> rsp_valid_i && $stable(rsp_i));

endmodule

`default_nettype wire

// File: soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top (
  input  wire                       clk,
  input  wire                       rst_n_i,
  input  wire                       ar_valid_i,
  output logic                      ar_ready_o,
  input  wire soc_mem_pkg::axi_id_t ar_id_i,
  input  wire soc_mem_pkg::addr_t   ar_addr_i,
  output logic                      r_valid_o,
  input  wire                       r_ready_i,
  output soc_mem_pkg::axi_id_t      r_id_o,
  output soc_mem_pkg::data_t        r_data_o,
  output soc_mem_pkg::resp_t        r_resp_o,
  input  wire                       aw_valid_i,
  output logic                      aw_ready_o,
  input  wire soc_mem_pkg::axi_id_t aw_id_i,
  input  wire soc_mem_pkg::addr_t   aw_addr_i,
  input  wire                       w_valid_i,
  output logic                      w_ready_o,
  input  wire soc_mem_pkg::data_t   w_data_i,
  input  wire soc_mem_pkg::strb_t   w_strb_i,
  output logic                      b_valid_o,
  input  wire                       b_ready_i,
  output soc_mem_pkg::axi_id_t      b_id_o,
  output soc_mem_pkg::resp_t        b_resp_o,
  output logic                      serial_valid_o,
  output soc_mem_pkg::byte_t        serial_data_o
);
  import soc_mem_pkg::*;

  logic     req_valid;
  logic     req_ready;
  bus_req_t req;
  logic     rsp_valid;
  logic     rsp_ready;
  bus_rsp_t rsp;

  bus_decode i_bus_decode (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .ar_id_i     (ar_id_i),
    .ar_addr_i   (ar_addr_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .aw_id_i     (aw_id_i),
    .aw_addr_i   (aw_addr_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .w_data_i    (w_data_i),
    .w_strb_i    (w_strb_i),
    .req_valid_o (req_valid),
    .req_ready_i (req_ready),
    .req_o       (req)
  );

  mem_execute i_mem_execute (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .req_i          (req),
    .rsp_valid_o    (rsp_valid),
    .rsp_ready_i    (rsp_ready),
    .rsp_o          (rsp),
    .serial_valid_o (serial_valid_o),
    .serial_data_o  (serial_data_o)
  );

  resp_result i_resp_result (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rsp_valid_i (rsp_valid),
    .rsp_ready_o (rsp_ready),
    .rsp_i       (rsp),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_id_o      (r_id_o),
    .r_data_o    (r_data_o),
    .r_resp_o    (r_resp_o),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .b_id_o      (b_id_o),
    .b_resp_o    (b_resp_o)
  );

endmodule

`default_nettype wire

// File: tb_soc_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_defines.svh"

module tb_soc_mem;
  import soc_mem_pkg::*;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_RD_WR
  } op_e;

  typedef struct packed {
    op_e     op;
    axi_id_t id;
    addr_t   addr;
    data_t   data;
    strb_t   strb;
    resp_t   exp_resp;
  } entry_t;

  localparam int    NUM_ENTRIES    = 17;
  localparam int    TIMEOUT_CYCLES = NUM_ENTRIES * 40;
  localparam addr_t BASE           = `SOC_MEM_BASE;
  localparam addr_t SERIAL         = `SOC_SERIAL_ADDR;
  localparam addr_t MEM_BYTES      = addr_t'(`SOC_MEM_WORDS * 8);

  logic    clk;
  logic    rst_n_i;
  logic    ar_valid_i;
  logic    ar_ready_o;
  axi_id_t ar_id_i;
  addr_t   ar_addr_i;
  logic    r_valid_o;
  logic    r_ready_i;
  axi_id_t r_id_o;
  data_t   r_data_o;
  resp_t   r_resp_o;
  logic    aw_valid_i;
  logic    aw_ready_o;
  axi_id_t aw_id_i;
  addr_t   aw_addr_i;
  logic    w_valid_i;
  logic    w_ready_o;
  data_t   w_data_i;
  strb_t   w_strb_i;
  logic    b_valid_o;
  logic    b_ready_i;
  axi_id_t b_id_o;
  resp_t   b_resp_o;
  logic    serial_valid_o;
  byte_t   serial_data_o;

  entry_t stim_table [NUM_ENTRIES];
  data_t  ref_mem [int];
  byte_t  serial_q [$];
  byte_t  exp_serial_q [$];
  integer seed;

  soc_mem_top i_soc_mem_top (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .ar_id_i        (ar_id_i),
    .ar_addr_i      (ar_addr_i),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .r_id_o         (r_id_o),
    .r_data_o       (r_data_o),
    .r_resp_o       (r_resp_o),
    .aw_valid_i     (aw_valid_i),
    .aw_ready_o     (aw_ready_o),
    .aw_id_i        (aw_id_i),
    .aw_addr_i      (aw_addr_i),
    .w_valid_i      (w_valid_i),
    .w_ready_o      (w_ready_o),
    .w_data_i       (w_data_i),
    .w_strb_i       (w_strb_i),
    .b_valid_o      (b_valid_o),
    .b_ready_i      (b_ready_i),
    .b_id_o         (b_id_o),
    .b_resp_o       (b_resp_o),
    .serial_valid_o (serial_valid_o),
    .serial_data_o  (serial_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_with_error(string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_read(axi_id_t exp_id, data_t exp_data, resp_t exp_resp);
    if (r_id_o !== exp_id || r_data_o !== exp_data || r_resp_o !== exp_resp) begin
      stop_with_error($sformatf(
        "mismatch at %0t: R id %0h data %h resp %0d, expected id %0h data %h resp %0d",
        $time, r_id_o, r_data_o, r_resp_o, exp_id, exp_data, exp_resp));
    end
  endtask

  task automatic check_write(axi_id_t exp_id, resp_t exp_resp);
    if (b_id_o !== exp_id || b_resp_o !== exp_resp) begin
      stop_with_error($sformatf(
        "mismatch at %0t: B id %0h resp %0d, expected id %0h resp %0d",
        $time, b_id_o, b_resp_o, exp_id, exp_resp));
    end
  endtask

  task automatic check_serial(byte_t exp_byte, byte_t got_byte);
    if (got_byte !== exp_byte) begin
      stop_with_error($sformatf("mismatch at %0t: serial byte %h, expected %h",
        $time, got_byte, exp_byte));
    end
  endtask

  function automatic entry_t make_entry(op_e op, axi_id_t id, addr_t addr, data_t data,
                                        strb_t strb, resp_t exp_resp);
    entry_t e;
    e.op       = op;
    e.id       = id;
    e.addr     = addr;
    e.data     = data;
    e.strb     = strb;
    e.exp_resp = exp_resp;
    return e;
  endfunction

  function automatic target_e classify(addr_t a);
    if (a == SERIAL) begin
      return TGT_SERIAL;
    end
    if (a >= BASE && a < BASE + MEM_BYTES) begin
      return TGT_MEM;
    end
    return TGT_NONE;
  endfunction

  function automatic int word_of(addr_t a);
    addr_t off;
    off = a - BASE;
    return int'(off >> 3);
  endfunction

  // enabled bytes take the new data, the rest keep the old word
  function automatic data_t merge_bytes(data_t old, data_t wdata, strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic data_t expected_read(addr_t a);
    if (classify(a) != TGT_MEM) begin
      return '0;
    end
    return ref_mem[word_of(a)];
  endfunction

  function automatic int pick_stall();
    int r;
    r = $random(seed) & 7;
    if (r > 4) begin
      r = 0;
    end
    return r;
  endfunction

  task automatic fill_table();
    stim_table[0]  = make_entry(OP_WRITE, 4'h1, BASE, 64'h0123_4567_89AB_CDEF, 8'hFF,
                                RESP_OKAY);
    stim_table[1]  = make_entry(OP_READ, 4'h2, BASE, '0, '0, RESP_OKAY);
    stim_table[2]  = make_entry(OP_WRITE, 4'h3, BASE + 32'h8, 64'h1111_2222_3333_4444,
                                8'hFF, RESP_OKAY);
    stim_table[3]  = make_entry(OP_WRITE, 4'h4, BASE + 32'h8, 64'hAAAA_BBBB_CCCC_DDDD,
                                8'h0F, RESP_OKAY);
    stim_table[4]  = make_entry(OP_WRITE, 4'h5, BASE + 32'h8, 64'h5A5A_0000_7E7E_0000,
                                8'hA0, RESP_OKAY);
    stim_table[5]  = make_entry(OP_READ, 4'h6, BASE + 32'h8, '0, '0, RESP_OKAY);
    // only the low byte goes out on the serial line
    stim_table[6]  = make_entry(OP_WRITE, 4'h7, SERIAL, 64'hDEAD_BEEF_0000_1248, 8'hFF,
                                RESP_OKAY);
    stim_table[7]  = make_entry(OP_WRITE, 4'h8, SERIAL, 64'h0000_0000_0000_0069, 8'h01,
                                RESP_OKAY);
    stim_table[8]  = make_entry(OP_READ, 4'h9, SERIAL, '0, '0, RESP_OKAY);
    stim_table[9]  = make_entry(OP_WRITE, 4'hA, 32'h9000_0000, 64'h7777_7777_7777_7777,
                                8'hFF, RESP_DECERR);
    stim_table[10] = make_entry(OP_READ, 4'hB, 32'h9000_0000, '0, '0, RESP_DECERR);
    // one past the end, would alias word 0 if decoded wrongly
    stim_table[11] = make_entry(OP_WRITE, 4'hC, BASE + MEM_BYTES, 64'hFFFF_FFFF_FFFF_FFFF,
                                8'hFF, RESP_DECERR);
    stim_table[12] = make_entry(OP_READ, 4'hD, BASE, '0, '0, RESP_OKAY);
    stim_table[13] = make_entry(OP_WRITE, 4'hE, BASE + MEM_BYTES - 32'h8,
                                64'hCAFE_F00D_1234_5678, 8'hFF, RESP_OKAY);
    stim_table[14] = make_entry(OP_RD_WR, 4'hF, BASE + MEM_BYTES - 32'h8,
                                64'h0102_0304_0506_0708, 8'h3C, RESP_OKAY);
    stim_table[15] = make_entry(OP_READ, 4'h0, BASE + MEM_BYTES - 32'h8, '0, '0,
                                RESP_OKAY);
    stim_table[16] = make_entry(OP_READ, 4'h1, BASE + 32'h8, '0, '0, RESP_OKAY);
  endtask

  task automatic expect_write_blocked();
    if (aw_valid_i && (aw_ready_o || w_ready_o)) begin
      stop_with_error("write channel was ready while a read was pending");
    end
  endtask

  task automatic send_read(entry_t e);
    ar_valid_i = 1'b1;
    ar_id_i    = e.id;
    ar_addr_i  = e.addr;
    #1;
    expect_write_blocked();
    while (!ar_ready_o) begin
      @(negedge clk);
      #1;
      expect_write_blocked();
    end
    @(negedge clk);
    ar_valid_i = 1'b0;
  endtask

  task automatic send_write(entry_t e);
    aw_valid_i = 1'b1;
    aw_id_i    = e.id;
    aw_addr_i  = e.addr;
    w_valid_i  = 1'b1;
    w_data_i   = e.data;
    w_strb_i   = e.strb;
    #1;
    while (!(aw_ready_o && w_ready_o)) begin
      if (aw_ready_o != w_ready_o) begin
        stop_with_error("AW and W were not accepted in the same cycle");
      end
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
  endtask

  // AR and AW/W raised together, the read has to go first
  task automatic send_both(entry_t e);
    aw_valid_i = 1'b1;
    aw_id_i    = e.id;
    aw_addr_i  = e.addr;
    w_valid_i  = 1'b1;
    w_data_i   = e.data;
    w_strb_i   = e.strb;
    send_read(e);
    send_write(e);
  endtask

  task automatic collect_read(axi_id_t exp_id, data_t exp_data, resp_t exp_resp);
    int stall;
    stall = pick_stall();
    while (!r_valid_o) begin
      if (b_valid_o) begin
        stop_with_error("write response arrived ahead of a pending read");
      end
      @(negedge clk);
    end
    repeat (stall) begin
      check_read(exp_id, exp_data, exp_resp);
      @(negedge clk);
      if (!r_valid_o) begin
        stop_with_error("R valid dropped without a handshake");
      end
    end
    check_read(exp_id, exp_data, exp_resp);
    r_ready_i = 1'b1;
    @(negedge clk);
    r_ready_i = 1'b0;
  endtask

  task automatic collect_write(axi_id_t exp_id, resp_t exp_resp);
    int stall;
    stall = pick_stall();
    while (!b_valid_o) begin
      if (r_valid_o) begin
        stop_with_error("read response appeared where a write response was due");
      end
      @(negedge clk);
    end
    repeat (stall) begin
      check_write(exp_id, exp_resp);
      @(negedge clk);
      if (!b_valid_o) begin
        stop_with_error("B valid dropped without a handshake");
      end
    end
    check_write(exp_id, exp_resp);
    b_ready_i = 1'b1;
    @(negedge clk);
    b_ready_i = 1'b0;
  endtask

  task automatic update_model(entry_t e);
    int idx;
    case (classify(e.addr))
      TGT_MEM: begin
        idx = word_of(e.addr);
        ref_mem[idx] = merge_bytes(ref_mem.exists(idx) ? ref_mem[idx] : '0, e.data, e.strb);
      end
      TGT_SERIAL: begin
        exp_serial_q.push_back(e.data[7:0]);
        if (serial_q.size() != exp_serial_q.size()) begin
          stop_with_error("serial write did not produce exactly one byte");
        end
        check_serial(exp_serial_q[$], serial_q[$]);
      end
      default: begin
      end
    endcase
  endtask

  task automatic run_entry(entry_t e);
    data_t exp_data;
    exp_data = '0;
    if (e.op != OP_WRITE) begin
      exp_data = expected_read(e.addr);
    end
    case (e.op)
      OP_READ: begin
        send_read(e);
        collect_read(e.id, exp_data, e.exp_resp);
      end
      OP_WRITE: begin
        send_write(e);
        collect_write(e.id, e.exp_resp);
        update_model(e);
      end
      default: begin
        send_both(e);
        collect_read(e.id, exp_data, e.exp_resp);
        collect_write(e.id, e.exp_resp);
        update_model(e);
      end
    endcase
  endtask

  always @(negedge clk) begin
    if (rst_n_i && serial_valid_o) begin
      serial_q.push_back(serial_data_o);
    end
  end

  always @(negedge clk) begin
    if (rst_n_i && r_valid_o && b_valid_o) begin
      stop_with_error("R and B were valid in the same cycle");
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    stop_with_error("a response never arrived before the watchdog limit");
  end

  initial begin
    seed       = 32'h9014_d616;
    rst_n_i    = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    r_ready_i  = 1'b0;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    fill_table();
    repeat (3) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_entry(stim_table[i]);
    end
    // let any stray serial byte show up
    repeat (4) @(negedge clk);
    if (serial_q.size() != exp_serial_q.size()) begin
      stop_with_error("serial byte count differs from the serial writes issued");
    end else begin
      foreach (exp_serial_q[k]) begin
        check_serial(exp_serial_q[k], serial_q[k]);
      end
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
soc_mem_pkg.sv
bus_decode.sv
mem_execute.sv
resp_result.sv
soc_mem_top.sv
tb_soc_mem.sv

// File: Makefile
TOP := tb_soc_mem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir
